//--- include/gpio_params.svh
`ifndef GPIO_PARAMS_SVH
`define GPIO_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// GPIO port geometry
////////////////////////////////////////////////////////////////////////////

// Number of GPIO pins, one bus word at most
`define GPIO_GW 32

// Synchronizer depth on gpio_i, zero bypasses the chain
`define GPIO_CDC 2

////////////////////////////////////////////////////////////////////////////
// TCB-Lite bus geometry
////////////////////////////////////////////////////////////////////////////

// Data word width
`define TCB_DAT 32
// Word address width, four registers
`define TCB_ADR 2
// One enable per data byte
`define TCB_BEN (`TCB_DAT/8)

`endif

//--- verilog/gpio_pkg.sv
`include "gpio_params.svh"

package gpio_pkg;

    ////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////

    // Word addresses of the GPIO registers
    typedef enum logic [`TCB_ADR-1:0] {
        GPIO_OUT = 2'd0,  // output data, read and write
        GPIO_ENA = 2'd1,  // output enable, read and write
        GPIO_IN  = 2'd2,  // synchronized input, read only
        GPIO_RSV = 2'd3   // unmapped, answers with an error
    } gpio_reg_e;

    ////////////////////////////////////////////////////////////////////////
    // Bus transfer types
    ////////////////////////////////////////////////////////////////////////

    // Request fields, qualified by vld
    typedef struct packed {
        // Write when set, read otherwise
        logic                wen;
        // Word address
        logic [`TCB_ADR-1:0] adr;
        // Byte enables, only used by writes
        logic [`TCB_BEN-1:0] ben;
        // Write data
        logic [`TCB_DAT-1:0] wdt;
    } tcb_req_t;

    // Response fields, valid one cycle after the transfer
    typedef struct packed {
        logic [`TCB_DAT-1:0] rdt;
        logic                err;
    } tcb_rsp_t;

endpackage: gpio_pkg

//--- verilog/tcb_lite_if.sv
`timescale 1ns/100ps

interface tcb_lite_if
    import gpio_pkg::*;
(
    // System clock and synchronous reset
    input logic clk,
    input logic rst
);

    ////////////////////////////////////////////////////////////////////////
    // Bus signals
    ////////////////////////////////////////////////////////////////////////

    // Transfer strobe, no ready since the peripheral never stalls
    logic     vld;
    // Request payload
    tcb_req_t req;
    // Registered response, one cycle after the transfer
    tcb_rsp_t rsp;

    ////////////////////////////////////////////////////////////////////////
    // Modports
    ////////////////////////////////////////////////////////////////////////

    // Manager issues transfers and collects responses
    modport man (
        input  clk,
        input  rst,
        output vld,
        output req,
        input  rsp
    );

    // Subordinate accepts every transfer
    modport sub (
        input  clk,
        input  rst,
        input  vld,
        input  req,
        output rsp
    );

endinterface: tcb_lite_if

//--- verilog/gpio_sync.sv
`timescale 1ns/100ps

`include "gpio_params.svh"

module gpio_sync #(
    // Pin count
    int unsigned GW  = `GPIO_GW,
    // Number of flip-flop stages, 0 for bypass
    int unsigned CDC = `GPIO_CDC
)(
    input  logic          clk,
    input  logic          rst,
    // Asynchronous pins
    input  logic [GW-1:0] gpio_i,
    // Pins in the clk domain
    output logic [GW-1:0] gpio_s
);

    if (CDC == 0) begin: gen_bypass

        // Pins already synchronous to clk
        assign gpio_s = gpio_i;

    end else begin: gen_chain

        // Stage 0 samples the pins, last stage is the output
        logic [GW-1:0] sync_q [CDC];

        always_ff @(posedge clk) begin
            if (rst) begin
                for (int i = 0; i < CDC; i++) begin
                    sync_q[i] <= '0;
                end
            end else begin
                sync_q[0] <= gpio_i;
                // Shift towards the output
                for (int i = 1; i < CDC; i++) begin
                    sync_q[i] <= sync_q[i-1];
                end
            end
        end

        assign gpio_s = sync_q[CDC-1];

    end

endmodule: gpio_sync

//--- verilog/gpio_regs.sv
`timescale 1ns/100ps

`include "gpio_params.svh"

module gpio_regs
    import gpio_pkg::*;
#(
    // Pin count, not wider than the bus word
    int unsigned GW = `GPIO_GW
)(
    input  logic                clk,
    input  logic                rst,
    // Transfer strobes
    input  logic                wen,
    input  logic                ren,
    // Request fields
    input  gpio_reg_e           adr,
    input  logic [`TCB_BEN-1:0] ben,
    input  logic [`TCB_DAT-1:0] wdt,
    // Synchronized input pins
    input  logic [GW-1:0]       gpio_s,
    // Pin drivers
    output logic [GW-1:0]       gpio_o,
    output logic [GW-1:0]       gpio_e,
    // Unregistered response
    output logic [`TCB_DAT-1:0] rdt,
    output logic                err
);

    ////////////////////////////////////////////////////////////////////////
    // Write decode
    ////////////////////////////////////////////////////////////////////////

    // Byte enables widened to one bit per data bit
    logic [`TCB_DAT-1:0] bit_mask;
    // Per-register write strobes
    logic                wen_out;
    logic                wen_ena;

    always_comb begin
        for (int b = 0; b < `TCB_BEN; b++) begin
            bit_mask[8*b +: 8] = {8{ben[b]}};
        end
    end

    assign wen_out = wen & (adr == GPIO_OUT);
    assign wen_ena = wen & (adr == GPIO_ENA);

    // OUTPUT and ENABLE, only enabled bytes take new data
    always_ff @(posedge clk) begin
        if (rst) begin
            gpio_o <= '0;
            gpio_e <= '0;
        end else begin
            if (wen_out) begin
                gpio_o <= (gpio_o & ~bit_mask[GW-1:0]) | (wdt[GW-1:0] & bit_mask[GW-1:0]);
            end
            if (wen_ena) begin
                gpio_e <= (gpio_e & ~bit_mask[GW-1:0]) | (wdt[GW-1:0] & bit_mask[GW-1:0]);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////////////////////////////////////

    // Zero-extended to the bus width, zero when not reading
    always_comb begin
        rdt = '0;
        if (ren) begin
            case (adr)
                GPIO_OUT: rdt[GW-1:0] = gpio_o;
                GPIO_ENA: rdt[GW-1:0] = gpio_e;
                GPIO_IN:  rdt[GW-1:0] = gpio_s;
                default:  rdt = '0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Error detection
    ////////////////////////////////////////////////////////////////////////

    // INPUT is read only, the last word is unmapped
    assign err = (wen & ((adr == GPIO_IN) | (adr == GPIO_RSV)))
               | (ren & (adr == GPIO_RSV));

endmodule: gpio_regs

//--- verilog/tcb_lite_peri_gpio.sv
`timescale 1ns/100ps

`include "gpio_params.svh"

module tcb_lite_peri_gpio
    import gpio_pkg::*;
#(
    // Pin count
    int unsigned GW  = `GPIO_GW,
    // Synchronizer depth, 0 for bypass
    int unsigned CDC = `GPIO_CDC
)(
    // GPIO pins
    output logic [GW-1:0] gpio_o,
    output logic [GW-1:0] gpio_e,
    input  logic [GW-1:0] gpio_i,
    // Bus subordinate port
    tcb_lite_if.sub       sub
);

    // Pins must fit in one bus word
    if (GW > `TCB_DAT) begin: gen_gw_check
        $error("GPIO width %0d exceeds bus data width %0d", GW, `TCB_DAT);
    end

    ////////////////////////////////////////////////////////////////////////
    // Local signals
    ////////////////////////////////////////////////////////////////////////

    logic                wen;
    logic                ren;
    logic [GW-1:0]       gpio_s;
    logic [`TCB_DAT-1:0] rdt;
    logic                err;

    // Every valid cycle is a transfer
    assign wen = sub.vld &  sub.req.wen;
    assign ren = sub.vld & ~sub.req.wen;

    ////////////////////////////////////////////////////////////////////////
    // Input synchronizer and register file
    ////////////////////////////////////////////////////////////////////////

    gpio_sync #(
        .GW  (GW),
        .CDC (CDC)
    ) sync (
        .clk    (sub.clk),
        .rst    (sub.rst),
        .gpio_i (gpio_i),
        .gpio_s (gpio_s)
    );

    gpio_regs #(
        .GW (GW)
    ) regs (
        .clk    (sub.clk),
        .rst    (sub.rst),
        .wen    (wen),
        .ren    (ren),
        .adr    (gpio_reg_e'(sub.req.adr)),
        .ben    (sub.req.ben),
        .wdt    (sub.req.wdt),
        .gpio_s (gpio_s),
        .gpio_o (gpio_o),
        .gpio_e (gpio_e),
        .rdt    (rdt),
        .err    (err)
    );

    ////////////////////////////////////////////////////////////////////////
    // Response stage
    ////////////////////////////////////////////////////////////////////////

    // One cycle delay, held until the next transfer
    always_ff @(posedge sub.clk) begin
        if (sub.rst) begin
            sub.rsp <= '0;
        end else if (sub.vld) begin
            sub.rsp.rdt <= rdt;
            sub.rsp.err <= err;
        end
    end

endmodule: tcb_lite_peri_gpio

//--- verilog/gpio_top.sv
`timescale 1ns/100ps

`include "gpio_params.svh"

module gpio_top (
    input  logic                clk,
    input  logic                rst,
    // Bus request
    input  logic                vld,
    input  logic                wen,
    input  logic [`TCB_ADR-1:0] adr,
    input  logic [`TCB_BEN-1:0] ben,
    input  logic [`TCB_DAT-1:0] wdt,
    // GPIO pins
    input  logic [`GPIO_GW-1:0] gpio_i,
    output logic [`GPIO_GW-1:0] gpio_o,
    output logic [`GPIO_GW-1:0] gpio_e,
    // Bus response
    output logic [`TCB_DAT-1:0] rsp_rdt,
    output logic                rsp_err
);

    ////////////////////////////////////////////////////////////////////////
    // Bus interface
    ////////////////////////////////////////////////////////////////////////

    tcb_lite_if bus (
        .clk (clk),
        .rst (rst)
    );

    // Plain request ports onto the bus
    assign bus.vld     = vld;
    assign bus.req.wen = wen;
    assign bus.req.adr = adr;
    assign bus.req.ben = ben;
    assign bus.req.wdt = wdt;

    // Response back out to plain ports
    assign rsp_rdt = bus.rsp.rdt;
    assign rsp_err = bus.rsp.err;

    ////////////////////////////////////////////////////////////////////////
    // GPIO peripheral
    ////////////////////////////////////////////////////////////////////////

    tcb_lite_peri_gpio #(
        .GW  (`GPIO_GW),
        .CDC (`GPIO_CDC)
    ) gpio (
        .gpio_o (gpio_o),
        .gpio_e (gpio_e),
        .gpio_i (gpio_i),
        .sub    (bus)
    );

endmodule: gpio_top

//--- test/gpio_props.sv
`timescale 1ns/100ps

`include "gpio_params.svh"

module gpio_props
    import gpio_pkg::*;
(
    input logic                clk,
    input logic                rst,
    // Transfer strobe and decoded read
    input logic                vld,
    input logic                ren,
    input logic [`TCB_ADR-1:0] adr,
    // Registered response
    input logic [`TCB_DAT-1:0] rsp_rdt,
    input logic                rsp_err,
    // Pin drivers
    input logic [`GPIO_GW-1:0] gpio_o,
    input logic [`GPIO_GW-1:0] gpio_e
);

    ////////////////////////////////////////////////////////////////////////
    // Response timing
    ////////////////////////////////////////////////////////////////////////

    // No transfer last cycle, so the response holds
    rsp_hold: assert property (@(posedge clk) disable iff (rst)
        (!$past(vld) && !$past(rst)) |-> ($stable(rsp_rdt) && $stable(rsp_err)))
        else $error("response changed without a transfer");

    // OUTPUT is always readable
    out_read_ok: assert property (@(posedge clk) disable iff (rst)
        (ren && adr == GPIO_OUT) |=> !rsp_err)
        else $error("error flag raised on a read of OUTPUT");

    ////////////////////////////////////////////////////////////////////////
    // Reset state
    ////////////////////////////////////////////////////////////////////////

    pins_reset: assert property (@(posedge clk)
        $past(rst) |-> (gpio_o == '0 && gpio_e == '0))
        else $error("pin drivers not cleared by reset");

endmodule: gpio_props

// Attached to every GPIO peripheral
bind tcb_lite_peri_gpio gpio_props props (
    .clk     (sub.clk),
    .rst     (sub.rst),
    .vld     (sub.vld),
    .ren     (ren),
    .adr     (sub.req.adr),
    .rsp_rdt (sub.rsp.rdt),
    .rsp_err (sub.rsp.err),
    .gpio_o  (gpio_o),
    .gpio_e  (gpio_e)
);

//--- test/tb_gpio.sv
`timescale 1ns/100ps

`include "gpio_params.svh"

module tb_gpio
    import gpio_pkg::*;
();

    // Longest wait allowed, in clock cycles
    localparam int WAIT_LIMIT = 64;
    // Transfers in the back-to-back burst
    localparam int BURST_LEN  = 16;

    logic                clk;
    logic                rst;
    logic                vld;
    logic                wen;
    logic [`TCB_ADR-1:0] adr;
    logic [`TCB_BEN-1:0] ben;
    logic [`TCB_DAT-1:0] wdt;
    logic [`GPIO_GW-1:0] gpio_i;
    logic [`GPIO_GW-1:0] gpio_o;
    logic [`GPIO_GW-1:0] gpio_e;
    logic [`TCB_DAT-1:0] rsp_rdt;
    logic                rsp_err;

    int                  seed;
    // Register model, OUTPUT, ENABLE and the settled input
    logic [`TCB_DAT-1:0] out_m;
    logic [`TCB_DAT-1:0] ena_m;
    logic [`TCB_DAT-1:0] in_m;

    gpio_top uut (
        .clk     (clk),
        .rst     (rst),
        .vld     (vld),
        .wen     (wen),
        .adr     (adr),
        .ben     (ben),
        .wdt     (wdt),
        .gpio_i  (gpio_i),
        .gpio_o  (gpio_o),
        .gpio_e  (gpio_e),
        .rsp_rdt (rsp_rdt),
        .rsp_err (rsp_err)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////
    // Failure reporting and checks
    ////////////////////////////////////////////////////////////////////////

    task automatic report_error(input string line);
        $display("Checks failed");
        $display("%s", line);
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_word(input string what, input logic [`TCB_DAT-1:0] got,
                              input logic [`TCB_DAT-1:0] exp);
        assert (got === exp) else begin
            report_error($sformatf("error: %0d ns: %s is %h, expected %h",
                                   $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        assert (got === exp) else begin
            report_error($sformatf("error: %0d ns: %s is %b, expected %b",
                                   $time, what, got, exp));
        end
    endtask

    // Counted wait on rising edges
    task automatic wait_cycles(input int n);
        int count;
        count = 0;
        while (count < n) begin
            if (count >= WAIT_LIMIT) begin
                report_error("a wait ran past its cycle limit");
            end
            @(posedge clk);
            count++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Bus driver
    ////////////////////////////////////////////////////////////////////////

    // Taken on the edge after this one
    task automatic drive_req(input logic w, input gpio_reg_e a,
                             input logic [`TCB_BEN-1:0] b, input logic [`TCB_DAT-1:0] d);
        @(posedge clk);
        vld <= 1'b1;
        wen <= w;
        adr <= a;
        ben <= b;
        wdt <= d;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        vld <= 1'b0;
        wen <= 1'b0;
    endtask

    task automatic bus_write(input gpio_reg_e a, input logic [`TCB_BEN-1:0] b,
                             input logic [`TCB_DAT-1:0] d, output logic err_v);
        drive_req(1'b1, a, b, d);
        drive_idle();
        // Mid-cycle after the transfer edge
        @(negedge clk);
        err_v = rsp_err;
    endtask

    task automatic bus_read(input gpio_reg_e a, output logic [`TCB_DAT-1:0] rdt_v,
                            output logic err_v);
        drive_req(1'b0, a, '0, '0);
        drive_idle();
        @(negedge clk);
        rdt_v = rsp_rdt;
        err_v = rsp_err;
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////

    function automatic logic [`TCB_DAT-1:0] rand_word();
        return $random(seed);
    endfunction

    // New bytes only where enabled
    function automatic logic [`TCB_DAT-1:0] merge_bytes(input logic [`TCB_DAT-1:0] old_w,
            input logic [`TCB_DAT-1:0] new_w, input logic [`TCB_BEN-1:0] b);
        logic [`TCB_DAT-1:0] res;
        res = old_w;
        for (int k = 0; k < `TCB_BEN; k++) begin
            if (b[k]) res[8*k +: 8] = new_w[8*k +: 8];
        end
        return res;
    endfunction

    // Expected response of one transfer, updates the model for writes
    task automatic model_transfer(input logic w, input gpio_reg_e a,
            input logic [`TCB_BEN-1:0] b, input logic [`TCB_DAT-1:0] d,
            output logic [`TCB_DAT-1:0] rdt_e, output logic err_e);
        rdt_e = '0;
        if (w) begin
            err_e = (a == GPIO_IN) || (a == GPIO_RSV);
            if (a == GPIO_OUT) out_m = merge_bytes(out_m, d, b);
            if (a == GPIO_ENA) ena_m = merge_bytes(ena_m, d, b);
        end else begin
            err_e = (a == GPIO_RSV);
            if (a == GPIO_OUT) rdt_e = out_m;
            if (a == GPIO_ENA) rdt_e = ena_m;
            if (a == GPIO_IN)  rdt_e = in_m;
        end
    endtask

    task automatic read_reg(input gpio_reg_e a);
        logic [`TCB_DAT-1:0] rdt_e;
        logic [`TCB_DAT-1:0] rdt_v;
        logic                err_e;
        logic                err_v;
        model_transfer(1'b0, a, '0, '0, rdt_e, err_e);
        bus_read(a, rdt_v, err_v);
        check_word($sformatf("read data of word %0d", a), rdt_v, rdt_e);
        check_bit($sformatf("read err of word %0d", a), err_v, err_e);
    endtask

    // Write, then check pins and read both registers back
    task automatic write_reg(input gpio_reg_e a, input logic [`TCB_BEN-1:0] b,
                             input logic [`TCB_DAT-1:0] d);
        logic [`TCB_DAT-1:0] rdt_e;
        logic                err_e;
        logic                err_v;
        model_transfer(1'b1, a, b, d, rdt_e, err_e);
        bus_write(a, b, d, err_v);
        check_bit($sformatf("write err of word %0d", a), err_v, err_e);
        check_word("gpio_o", gpio_o, out_m);
        check_word("gpio_e", gpio_e, ena_m);
        read_reg(GPIO_OUT);
        read_reg(GPIO_ENA);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////

    task automatic reset_state();
        check_word("gpio_o after reset", gpio_o, '0);
        check_word("gpio_e after reset", gpio_e, '0);
        check_word("rsp_rdt after reset", rsp_rdt, '0);
        check_bit("rsp_err after reset", rsp_err, 1'b0);
        read_reg(GPIO_OUT);
        read_reg(GPIO_ENA);
    endtask

    task automatic write_readback();
        for (int i = 0; i < 4; i++) begin
            write_reg(GPIO_OUT, '1, rand_word());
            write_reg(GPIO_ENA, '1, rand_word());
        end
    endtask

    task automatic byte_masking();
        logic [`TCB_DAT-1:0] r;
        for (int i = 0; i < 8; i++) begin
            r = rand_word();
            if (r[4]) write_reg(GPIO_ENA, r[3:0], rand_word());
            else write_reg(GPIO_OUT, r[3:0], rand_word());
        end
    endtask

    task automatic input_path();
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            in_m = rand_word();
            gpio_i <= in_m;
            // Beyond the synchronizer depth
            wait_cycles(`GPIO_CDC + 2);
            read_reg(GPIO_IN);
            read_reg(GPIO_OUT);
            check_word("gpio_o during input test", gpio_o, out_m);
        end
    endtask

    task automatic error_responses();
        write_reg(GPIO_IN, '1, rand_word());
        write_reg(GPIO_RSV, '1, rand_word());
        write_reg(GPIO_RSV, 4'b0101, rand_word());
        read_reg(GPIO_RSV);
    endtask

    // Random transfers with vld held high, each response one cycle later
    task automatic back_to_back();
        logic [`TCB_DAT-1:0] r;
        logic [`TCB_DAT-1:0] d;
        logic [`TCB_DAT-1:0] rdt_e;
        logic [`TCB_DAT-1:0] prev_rdt;
        logic                err_e;
        logic                prev_err;
        logic                prev_w;
        gpio_reg_e           a;
        for (int i = 0; i <= BURST_LEN; i++) begin
            @(posedge clk);
            if (i < BURST_LEN) begin
                r = rand_word();
                d = rand_word();
                a = gpio_reg_e'(r[1:0]);
                model_transfer(r[31], a, r[7:4], d, rdt_e, err_e);
                vld <= 1'b1;
                wen <= r[31];
                adr <= a;
                ben <= r[7:4];
                wdt <= d;
            end else begin
                vld <= 1'b0;
                wen <= 1'b0;
            end
            @(negedge clk);
            // Response of the transfer driven one cycle earlier
            if (i > 0) begin
                if (!prev_w) check_word("burst read data", rsp_rdt, prev_rdt);
                check_bit("burst err", rsp_err, prev_err);
            end
            prev_w   = r[31];
            prev_rdt = rdt_e;
            prev_err = err_e;
        end
        check_word("gpio_o after burst", gpio_o, out_m);
        check_word("gpio_e after burst", gpio_e, ena_m);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////

    initial begin
        seed   = 32'h2c30;
        clk    = 1'b0;
        rst    = 1'b1;
        vld    = 1'b0;
        wen    = 1'b0;
        adr    = '0;
        ben    = '0;
        wdt    = '0;
        gpio_i = '0;
        out_m  = '0;
        ena_m  = '0;
        in_m   = '0;
        // Reset over two edges
        wait_cycles(2);
        rst <= 1'b0;
        @(negedge clk);
        reset_state();
        write_readback();
        byte_masking();
        input_path();
        error_responses();
        back_to_back();
        $display("All checks passed");
        $finish;
    end

endmodule: tb_gpio

//--- flist.f
+incdir+include
verilog/gpio_pkg.sv
verilog/tcb_lite_if.sv
verilog/gpio_sync.sv
verilog/gpio_regs.sv
verilog/tcb_lite_peri_gpio.sv
verilog/gpio_top.sv
test/gpio_props.sv
test/tb_gpio.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the GPIO testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

# Build the simulator from the file list
verilator --binary --timing --assert --top-module tb_gpio \
    -Mdir "$OBJ" -o tb_gpio -f flist.f
if [ $? -ne 0 ]; then
    echo "FAIL: Verilator build failed"
    exit 1
fi

# Run it and keep the output for the result search
"./$OBJ/tb_gpio" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "FAIL: simulation exited with status $status"
    exit 1
fi

# Only the pass message counts as success
if grep -q "All checks passed" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL: pass message not found in $LOG"
    exit 1
fi
